// File: logic/adc_capture.sv
`timescale 1ns/10ps

module adc_capture
    import radio_pkg::*;
#(
    parameter int BUF_ADDR_W = 12
)
(
    input  logic                  led_clk,
    input  logic                  adc_dpram_rst,
    input  logic [ADC_W-1:0]      adc_data,
    input  logic                  adc_of,
    input  logic                  cap_trig,
    input  logic [BUF_ADDR_W-1:0] cap_rd_addr,
    output logic                  cap_busy,
    output logic [BUF_ADDR_W-1:0] cap_wr_addr,
    output logic [SAMPLE_W-1:0]   cap_rd_data
);

    localparam int BUF_DEPTH = 2 ** BUF_ADDR_W;

    cap_state_e          cap_state;
    logic [SAMPLE_W-1:0] sample_q;
    logic [SAMPLE_W-1:0] buf_mem [BUF_DEPTH];
    logic                wr_en;

    assign wr_en    = (cap_state == CAP_WRITE);
    assign cap_busy = wr_en;

    // Sample pipeline stage ahead of the buffer
    always_ff @(posedge led_clk)
    begin
        sample_q <= {adc_of, adc_data};
    end

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
        begin
            cap_state   <= CAP_IDLE;
            cap_wr_addr <= '0;
        end
        else
        begin
            case (cap_state)
                CAP_IDLE:
                begin
                    cap_wr_addr <= '0;
                    if (cap_trig)
                        cap_state <= CAP_WRITE;
                end
                CAP_WRITE:
                begin
                    cap_wr_addr <= cap_wr_addr + 1'b1; // Wraps back to zero at the end
                    if (&cap_wr_addr)
                        cap_state <= CAP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge led_clk)
    begin
        if (wr_en)
            buf_mem[cap_wr_addr] <= sample_q;
        cap_rd_data <= buf_mem[cap_rd_addr]; // One cycle read latency
    end

endmodule

// File: logic/irq_ctrl.sv
`timescale 1ns/10ps

module irq_ctrl
#(
    parameter int IRQ_COUNT = 8
)
(
    input  logic                 led_clk,
    input  logic                 adc_dpram_rst,
    input  logic                 cap_busy,
    input  logic                 adc_of,
    input  logic [IRQ_COUNT-1:0] irq_mask_smc,
    input  logic [IRQ_COUNT-1:0] irq_mask_dsp,
    input  logic [IRQ_COUNT-1:0] irq_clear,
    input  logic [IRQ_COUNT-1:0] irq_set,
    output logic [IRQ_COUNT-1:0] irq_state,
    output logic                 irq_smc_n,
    output logic                 irq_dsp_n
);

    logic [IRQ_COUNT-1:0] irq_lines;
    logic [IRQ_COUNT-1:0] line_q;
    logic [IRQ_COUNT-1:0] line_qq;
    logic [IRQ_COUNT-1:0] line_rise;

    always_comb
    begin
        irq_lines    = '0;        // Spare lines stay inactive
        irq_lines[0] = cap_busy;  // Capture start
        irq_lines[1] = !cap_busy; // Capture done
        irq_lines[2] = adc_of;
    end

    assign line_rise = line_q & ~line_qq;

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
        begin
            // Track the lines so release does not look like an edge
            line_q    <= irq_lines;
            line_qq   <= irq_lines;
            irq_state <= '0;
        end
        else
        begin
            line_q    <= irq_lines;
            line_qq   <= line_q;
            irq_state <= (irq_state & ~irq_clear) | line_rise | irq_set; // Set wins
        end
    end

    assign irq_smc_n = !(|(irq_state & irq_mask_smc));
    assign irq_dsp_n = !(|(irq_state & irq_mask_dsp));

endmodule

// File: logic/led_pwm.sv
`timescale 1ns/10ps

module led_pwm
#(
    parameter int LED_W = 12
)
(
    input  logic             led_clk,
    input  logic             adc_dpram_rst,
    input  logic             led_en,
    input  logic [LED_W-1:0] duty_red,
    input  logic [LED_W-1:0] duty_green,
    input  logic [LED_W-1:0] duty_blue,
    output logic             red_led,
    output logic             green_led,
    output logic             blue_led
);

    logic [LED_W-1:0] pwm_cnt; // Shared by all channels
    logic [LED_W-1:0] duty [3];
    logic [2:0]       led_q;

    assign duty[0] = duty_red;
    assign duty[1] = duty_green;
    assign duty[2] = duty_blue;

    assign red_led   = led_q[0];
    assign green_led = led_q[1];
    assign blue_led  = led_q[2];

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst || !led_en)
            pwm_cnt <= '0; // Held while disabled
        else
            pwm_cnt <= pwm_cnt + 1'b1;
    end

    // On at count zero, off at the duty match
    always_ff @(posedge led_clk)
    begin
        for (int i = 0; i < 3; i++)
        begin
            if (adc_dpram_rst || !led_en || (duty[i] == '0))
                led_q[i] <= 1'b0;
            else if (pwm_cnt == duty[i])
                led_q[i] <= 1'b0;
            else if (pwm_cnt == '0)
                led_q[i] <= 1'b1;
        end
    end

endmodule

// File: logic/radio_core.sv
`timescale 1ns/10ps

module radio_core
    import radio_pkg::*;
#(
    parameter int BUF_ADDR_W = 12,
    parameter int LED_W      = 12,
    parameter int IRQ_COUNT  = 8 // Register packing allows up to 8
)
(
    input  logic                  led_clk,
    input  logic                  adc_dpram_rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [6:0]            paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    input  logic [ADC_W-1:0]      adc_data,
    input  logic                  adc_of,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  red_led,
    output logic                  green_led,
    output logic                  blue_led,
    output logic                  irq_smc_n,
    output logic                  irq_dsp_n
);

    logic                  led_en;
    logic [LED_W-1:0]      duty_red;
    logic [LED_W-1:0]      duty_green;
    logic [LED_W-1:0]      duty_blue;
    logic [IRQ_COUNT-1:0]  irq_mask_smc;
    logic [IRQ_COUNT-1:0]  irq_mask_dsp;
    logic [IRQ_COUNT-1:0]  irq_clear;
    logic [IRQ_COUNT-1:0]  irq_set;
    logic [IRQ_COUNT-1:0]  irq_state;
    logic                  cap_trig;
    logic                  cap_busy;
    logic [BUF_ADDR_W-1:0] cap_rd_addr;
    logic [BUF_ADDR_W-1:0] cap_wr_addr;
    logic [SAMPLE_W-1:0]   cap_rd_data;

    radio_regs #(
        .BUF_ADDR_W(BUF_ADDR_W),
        .LED_W     (LED_W),
        .IRQ_COUNT (IRQ_COUNT)
    ) u_regs (
        .led_clk      (led_clk),
        .adc_dpram_rst(adc_dpram_rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .irq_state    (irq_state),
        .cap_busy     (cap_busy),
        .cap_wr_addr  (cap_wr_addr),
        .cap_rd_data  (cap_rd_data),
        .prdata       (prdata),
        .pready       (pready),
        .led_en       (led_en),
        .duty_red     (duty_red),
        .duty_green   (duty_green),
        .duty_blue    (duty_blue),
        .irq_mask_smc (irq_mask_smc),
        .irq_mask_dsp (irq_mask_dsp),
        .irq_clear    (irq_clear),
        .irq_set      (irq_set),
        .cap_trig     (cap_trig),
        .cap_rd_addr  (cap_rd_addr)
    );

    led_pwm #(
        .LED_W(LED_W)
    ) u_led_pwm (
        .led_clk      (led_clk),
        .adc_dpram_rst(adc_dpram_rst),
        .led_en       (led_en),
        .duty_red     (duty_red),
        .duty_green   (duty_green),
        .duty_blue    (duty_blue),
        .red_led      (red_led),
        .green_led    (green_led),
        .blue_led     (blue_led)
    );

    // Overflow goes straight to the interrupt block as line 2
    irq_ctrl #(
        .IRQ_COUNT(IRQ_COUNT)
    ) u_irq_ctrl (
        .led_clk      (led_clk),
        .adc_dpram_rst(adc_dpram_rst),
        .cap_busy     (cap_busy),
        .adc_of       (adc_of),
        .irq_mask_smc (irq_mask_smc),
        .irq_mask_dsp (irq_mask_dsp),
        .irq_clear    (irq_clear),
        .irq_set      (irq_set),
        .irq_state    (irq_state),
        .irq_smc_n    (irq_smc_n),
        .irq_dsp_n    (irq_dsp_n)
    );

    adc_capture #(
        .BUF_ADDR_W(BUF_ADDR_W)
    ) u_adc_capture (
        .led_clk      (led_clk),
        .adc_dpram_rst(adc_dpram_rst),
        .adc_data     (adc_data),
        .adc_of       (adc_of),
        .cap_trig     (cap_trig),
        .cap_rd_addr  (cap_rd_addr),
        .cap_busy     (cap_busy),
        .cap_wr_addr  (cap_wr_addr),
        .cap_rd_data  (cap_rd_data)
    );

endmodule

// File: logic/radio_pkg.sv
package radio_pkg;

    // Bus and sample widths
    localparam int APB_DATA_W = 32;
    localparam int ADC_W      = 16;
    localparam int SAMPLE_W   = ADC_W + 1; // Overflow flag sits above the data

    // Returned by REG_ID so the host can identify the bitstream
    localparam logic [APB_DATA_W-1:0] RADIO_ID = 32'hDADC0001;

    // Register index as seen on paddr
    typedef enum logic [6:0]
    {
        REG_ID         = 7'h00,
        REG_IRQ        = 7'h02, // Masks, clear, set and state
        REG_LED_CNTRL  = 7'h10,
        REG_RED_DUTY   = 7'h11,
        REG_GREEN_DUTY = 7'h12,
        REG_BLUE_DUTY  = 7'h13,
        REG_CAP_CNTRL  = 7'h20, // Trigger, auto-increment, busy
        REG_CAP_ADDR   = 7'h21,
        REG_CAP_DATA   = 7'h22  // One wait state on read
    } reg_addr_e;

    // Capture sequencer
    typedef enum logic
    {
        CAP_IDLE  = 1'b0,
        CAP_WRITE = 1'b1
    } cap_state_e;

endpackage

// File: logic/radio_regs.sv
`timescale 1ns/10ps

module radio_regs
    import radio_pkg::*;
#(
    parameter int BUF_ADDR_W = 12,
    parameter int LED_W      = 12,
    parameter int IRQ_COUNT  = 8
)
(
    input  logic                  led_clk,
    input  logic                  adc_dpram_rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [6:0]            paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    input  logic [IRQ_COUNT-1:0]  irq_state,
    input  logic                  cap_busy,
    input  logic [BUF_ADDR_W-1:0] cap_wr_addr,
    input  logic [SAMPLE_W-1:0]   cap_rd_data,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  led_en,
    output logic [LED_W-1:0]      duty_red,
    output logic [LED_W-1:0]      duty_green,
    output logic [LED_W-1:0]      duty_blue,
    output logic [IRQ_COUNT-1:0]  irq_mask_smc,
    output logic [IRQ_COUNT-1:0]  irq_mask_dsp,
    output logic [IRQ_COUNT-1:0]  irq_clear,
    output logic [IRQ_COUNT-1:0]  irq_set,
    output logic                  cap_trig,
    output logic [BUF_ADDR_W-1:0] cap_rd_addr
);

    reg_addr_e reg_idx;
    logic      access;
    logic      data_rd;
    logic      rd_wait; // Buffer word is being fetched
    logic      wr_done;
    logic      rd_done;
    logic      cap_auto_inc;

    assign reg_idx = reg_addr_e'(paddr);
    assign access  = psel && penable;
    assign data_rd = access && !pwrite && (reg_idx == REG_CAP_DATA);

    // Zero wait states except the first access cycle of a buffer read
    assign pready  = access && (!data_rd || rd_wait);
    assign wr_done = pready && pwrite;
    assign rd_done = pready && !pwrite;

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
            rd_wait <= 1'b0;
        else
            rd_wait <= data_rd && !rd_wait;
    end

    always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
        begin
            led_en       <= 1'b0;
            duty_red     <= '0;
            duty_green   <= '0;
            duty_blue    <= '0;
            irq_mask_smc <= '0;
            irq_mask_dsp <= '0;
            irq_clear    <= '0;
            irq_set      <= '0;
            cap_trig     <= 1'b0;
            cap_auto_inc <= 1'b0;
            cap_rd_addr  <= '0;
        end
        else
        begin
            // Strobes last one cycle
            irq_clear <= '0;
            irq_set   <= '0;
            cap_trig  <= 1'b0;

            if (wr_done)
            begin
                case (reg_idx)
                    REG_IRQ:
                    begin
                        irq_mask_smc <= pwdata[IRQ_COUNT-1:0];
                        irq_mask_dsp <= pwdata[8 +: IRQ_COUNT];
                        irq_clear    <= pwdata[16 +: IRQ_COUNT];
                        irq_set      <= pwdata[24 +: IRQ_COUNT];
                    end
                    REG_LED_CNTRL:  led_en     <= pwdata[0];
                    REG_RED_DUTY:   duty_red   <= pwdata[LED_W-1:0];
                    REG_GREEN_DUTY: duty_green <= pwdata[LED_W-1:0];
                    REG_BLUE_DUTY:  duty_blue  <= pwdata[LED_W-1:0];
                    REG_CAP_CNTRL:
                    begin
                        cap_trig     <= pwdata[0];
                        cap_auto_inc <= pwdata[1];
                    end
                    REG_CAP_ADDR:   cap_rd_addr <= pwdata[BUF_ADDR_W-1:0];
                    default: ; // Read-only or unmapped
                endcase
            end

            // Step to the next buffer word once the host has taken this one
            if (rd_done && (reg_idx == REG_CAP_DATA) && cap_auto_inc)
                cap_rd_addr <= cap_rd_addr + 1'b1;
        end
    end

    always_comb
    begin
        prdata = '0;
        case (reg_idx)
            REG_ID: prdata = RADIO_ID;
            REG_IRQ:
            begin
                prdata[IRQ_COUNT-1:0]   = irq_mask_smc;
                prdata[8 +: IRQ_COUNT]  = irq_mask_dsp;
                prdata[16 +: IRQ_COUNT] = irq_state;
            end
            REG_LED_CNTRL:  prdata[0]         = led_en;
            REG_RED_DUTY:   prdata[LED_W-1:0] = duty_red;
            REG_GREEN_DUTY: prdata[LED_W-1:0] = duty_green;
            REG_BLUE_DUTY:  prdata[LED_W-1:0] = duty_blue;
            REG_CAP_CNTRL:
            begin
                prdata[1] = cap_auto_inc;
                prdata[2] = cap_busy;
            end
            REG_CAP_ADDR:
            begin
                prdata[BUF_ADDR_W-1:0]   = cap_rd_addr;
                prdata[16 +: BUF_ADDR_W] = cap_wr_addr; // Write pointer in upper half
            end
            REG_CAP_DATA: prdata[SAMPLE_W-1:0] = cap_rd_data;
            default:      prdata = '0;
        endcase
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the radio_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_radio_core \
    -o sim_tb_radio_core \
    && ./obj_dir/sim_tb_radio_core | tee /dev/stderr | grep -q "^TB PASSED$" \
    && echo "simulation finished without errors" \
    || { echo "simulation reported failure"; exit 1; }

// File: verification/radio_core_sva.sv
`timescale 1ns/10ps

module radio_core_sva
#(
    parameter int IRQ_COUNT = 8
)
(
    input logic                 led_clk,
    input logic                 adc_dpram_rst,
    input logic                 psel,
    input logic                 penable,
    input logic                 pready,
    input logic                 cap_trig,
    input logic [IRQ_COUNT-1:0] irq_set,
    input logic [IRQ_COUNT-1:0] irq_clear,
    input logic [IRQ_COUNT-1:0] irq_state,
    input logic [IRQ_COUNT-1:0] irq_mask_smc,
    input logic [IRQ_COUNT-1:0] irq_mask_dsp
);

    pready_in_access: assert property (@(posedge led_clk) pready |-> (psel && penable))
        else $error("pready high outside an APB access phase");

    // Strobes from the register block
    trig_one_cycle: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        cap_trig |=> !cap_trig)
        else $error("cap_trig longer than one cycle");

    set_one_cycle: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        (|irq_set) |=> (irq_set == '0))
        else $error("irq_set longer than one cycle");

    clear_one_cycle: assert property (@(posedge led_clk) disable iff (adc_dpram_rst)
        (|irq_clear) |=> (irq_clear == '0))
        else $error("irq_clear longer than one cycle");

    // Outputs stay high once reset has reached state and masks
    irq_idle_in_reset: assert property (@(posedge led_clk)
        (adc_dpram_rst && $past(adc_dpram_rst)) |->
        (((irq_state & irq_mask_smc) == '0) && ((irq_state & irq_mask_dsp) == '0)))
        else $error("interrupt output active during reset");

endmodule

bind radio_regs radio_core_sva #(
    .IRQ_COUNT(IRQ_COUNT)
) u_sva (
    .led_clk      (led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .psel         (psel),
    .penable      (penable),
    .pready       (pready),
    .cap_trig     (cap_trig),
    .irq_set      (irq_set),
    .irq_clear    (irq_clear),
    .irq_state    (irq_state),
    .irq_mask_smc (irq_mask_smc),
    .irq_mask_dsp (irq_mask_dsp)
);

// File: verification/tb_radio_core.sv
`timescale 1ns/10ps

module tb_radio_core
    import radio_pkg::*;
();

    localparam int BUF_ADDR_W  = 6;
    localparam int LED_W       = 8;
    localparam int BUF_DEPTH   = 2 ** BUF_ADDR_W;
    localparam int PWM_PERIOD  = 2 ** LED_W;
    localparam int APB_TIMEOUT = 16;            // Access cycles before giving up
    localparam int POLL_LIMIT  = 4 * BUF_DEPTH; // Busy polls before giving up

    // Registers expected to read zero right after reset
    localparam reg_addr_e ZERO_REGS [7] = '{REG_IRQ, REG_LED_CNTRL, REG_RED_DUTY,
        REG_GREEN_DUTY, REG_BLUE_DUTY, REG_CAP_CNTRL, REG_CAP_ADDR};

    logic                  led_clk = 1'b0;
    logic                  adc_dpram_rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [6:0]            paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [ADC_W-1:0]      adc_data;
    logic                  adc_of;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  red_led;
    logic                  green_led;
    logic                  blue_led;
    logic                  irq_smc_n;
    logic                  irq_dsp_n;

    logic        of_enable; // Overflow source held off until the reset checks are done
    int unsigned cycle_cnt;
    int          errors;
    int          test_errors;
    int          checks;

    radio_core #(
        .BUF_ADDR_W(BUF_ADDR_W),
        .LED_W     (LED_W)
    ) u_dut (
        .led_clk      (led_clk),
        .adc_dpram_rst(adc_dpram_rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .adc_data     (adc_data),
        .adc_of       (adc_of),
        .prdata       (prdata),
        .pready       (pready),
        .red_led      (red_led),
        .green_led    (green_led),
        .blue_led     (blue_led),
        .irq_smc_n    (irq_smc_n),
        .irq_dsp_n    (irq_dsp_n)
    );

    always #20 led_clk = ~led_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // High cycles of one LED over a full PWM period
    function automatic int led_high_ref(input logic en, input logic [LED_W-1:0] duty);
        return (en && (duty != '0)) ? int'(duty) : 0;
    endfunction

    // Active-low output level for a state and mask pair
    function automatic logic irq_out_ref(input logic [7:0] state, input logic [7:0] mask);
        return (state & mask) == 8'h00;
    endfunction

    function automatic logic [ADC_W-1:0] ramp_next_ref(input logic [ADC_W-1:0] prev);
        return prev + 16'd1; // Wraps modulo 2^16
    endfunction

    function automatic logic [BUF_ADDR_W-1:0] rd_addr_ref(input logic [BUF_ADDR_W-1:0] start,
                                                          input int reads);
        return start + BUF_ADDR_W'(reads);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string title);
        if (test_errors == 0)
            $display("Test %s: ok", title);
        else
            $display("Test %s: %0d errors", title, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic wait_ready(output int waits);
        waits = 0;
        @(posedge led_clk);
        while (!pready && (waits < APB_TIMEOUT))
        begin
            waits++;
            @(posedge led_clk);
        end
        if (!pready)
            abort_run("APB access never saw pready");
    endtask

    task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
        int waits;
        @(posedge led_clk);
        psel    <= 1'b1; // Setup cycle
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge led_clk);
        penable <= 1'b1;
        wait_ready(waits);
        psel    <= 1'b0;
        penable <= 1'b0;
        compare_value("pready wait cycles", 32'(waits), 32'h0); // Writes never stall
    endtask

    task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
        int waits;
        @(posedge led_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge led_clk);
        penable <= 1'b1;
        wait_ready(waits);
        data     = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
        // Only a buffer read inserts a wait state
        compare_value("pready wait cycles", 32'(waits),
                      (addr == REG_CAP_DATA) ? 32'h1 : 32'h0);
    endtask

    task automatic wait_capture_idle();
        logic [31:0] rd;
        int          polls;
        polls = 0;
        apb_read(REG_CAP_CNTRL, rd);
        while (rd[2] && (polls < POLL_LIMIT))
        begin
            polls++;
            apb_read(REG_CAP_CNTRL, rd);
        end
        if (rd[2])
            abort_run("capture busy never fell");
    endtask

    // Count LED high cycles over one full PWM period
    task automatic measure_leds(output int r, output int g, output int b);
        r = 0;
        g = 0;
        b = 0;
        repeat (4) @(posedge led_clk);
        repeat (PWM_PERIOD)
        begin
            @(posedge led_clk);
            r += int'(red_led);
            g += int'(green_led);
            b += int'(blue_led);
        end
    endtask

    // ADC ramp, overflow source and cycle counter
    initial
    begin : adc_source
        logic [31:0] of_rng;
        adc_data  <= '0;
        adc_of    <= 1'b0;
        cycle_cnt <= 0;
        of_rng     = 32'd45259;
        forever
        begin
            @(posedge led_clk);
            cycle_cnt <= cycle_cnt + 1;
            adc_data  <= adc_data + 1'b1;
            if (of_enable && (cycle_cnt[3:0] == 4'h0))
            begin
                of_rng  = xorshift32(of_rng);
                adc_of <= of_rng[0];
            end
        end
    end

    initial
    begin : main_seq
        logic [31:0]      rd;
        logic [31:0]      duty_rng;
        logic [LED_W-1:0] duty [3];
        int               hi_r;
        int               hi_g;
        int               hi_b;
        logic [ADC_W-1:0] prev;
        int unsigned      t_start;
        int               elapsed;

        errors      = 0;
        test_errors = 0;
        checks      = 0;
        duty_rng    = 32'd45259;
        adc_dpram_rst <= 1'b1;
        psel          <= 1'b0;
        penable       <= 1'b0;
        pwrite        <= 1'b0;
        paddr         <= '0;
        pwdata        <= '0;
        of_enable     <= 1'b0;
        repeat (16) @(posedge led_clk);
        adc_dpram_rst <= 1'b0;

        apb_read(REG_ID, rd);
        compare_value("REG_ID", rd, RADIO_ID);
        for (int i = 0; i < 7; i++)
        begin
            apb_read(ZERO_REGS[i], rd);
            compare_value($sformatf("reg 0x%02h", ZERO_REGS[i]), rd, 32'h0);
        end
        apb_write(7'h05, 32'hFFFF_FFFF); // Unmapped index
        apb_read(7'h05, rd);
        compare_value("reg 0x05", rd, 32'h0);
        compare_value("irq_smc_n", 32'(irq_smc_n), 32'(1'b1));
        compare_value("irq_dsp_n", 32'(irq_dsp_n), 32'(1'b1));
        finish_test("reset values and ID");
        of_enable <= 1'b1;

        for (int c = 0; c < 3; c++)
        begin
            duty_rng = xorshift32(duty_rng);
            duty[c]  = LED_W'(duty_rng % (PWM_PERIOD - 1)) + 1'b1; // Nonzero
        end
        apb_write(REG_RED_DUTY, 32'(duty[0]));
        apb_write(REG_GREEN_DUTY, 32'(duty[1]));
        apb_write(REG_BLUE_DUTY, 32'(duty[2]));
        apb_write(REG_LED_CNTRL, 32'h1);
        measure_leds(hi_r, hi_g, hi_b);
        compare_value("red_led", 32'(hi_r), 32'(led_high_ref(1'b1, duty[0])));
        compare_value("green_led", 32'(hi_g), 32'(led_high_ref(1'b1, duty[1])));
        compare_value("blue_led", 32'(hi_b), 32'(led_high_ref(1'b1, duty[2])));
        apb_write(REG_RED_DUTY, 32'h0);
        measure_leds(hi_r, hi_g, hi_b);
        compare_value("red_led", 32'(hi_r), 32'(led_high_ref(1'b1, '0)));
        compare_value("green_led", 32'(hi_g), 32'(led_high_ref(1'b1, duty[1])));
        apb_write(REG_LED_CNTRL, 32'h0);
        measure_leds(hi_r, hi_g, hi_b);
        compare_value("green_led", 32'(hi_g), 32'(led_high_ref(1'b0, duty[1])));
        compare_value("blue_led", 32'(hi_b), 32'(led_high_ref(1'b0, duty[2])));
        finish_test("LED PWM");

        apb_write(REG_CAP_ADDR, 32'h0);
        apb_write(REG_CAP_CNTRL, 32'h3); // Trigger with auto-increment
        wait_capture_idle();
        prev = '0;
        for (int i = 0; i < BUF_DEPTH; i++)
        begin
            apb_read(REG_CAP_DATA, rd);
            if (i > 0)
                compare_value($sformatf("cap_rd_data[%0d]", i), 32'(rd[ADC_W-1:0]),
                              32'(ramp_next_ref(prev)));
            prev = rd[ADC_W-1:0];
        end
        apb_read(REG_CAP_ADDR, rd);
        compare_value("cap_rd_addr", 32'(rd[BUF_ADDR_W-1:0]), 32'(rd_addr_ref('0, BUF_DEPTH)));
        finish_test("capture ramp");

        apb_read(REG_IRQ, rd);
        compare_value("irq_state[1:0]", 32'(rd[17:16]), 32'(2'b11));
        apb_write(REG_IRQ, 32'h0000_0002); // SMC sees capture done only
        @(posedge led_clk);
        compare_value("irq_smc_n", 32'(irq_smc_n), 32'(irq_out_ref(8'h03, 8'h02)));
        compare_value("irq_dsp_n", 32'(irq_dsp_n), 32'(irq_out_ref(8'h03, 8'h00)));
        apb_write(REG_IRQ, 32'h0003_0002);
        repeat (2) @(posedge led_clk);
        compare_value("irq_smc_n", 32'(irq_smc_n), 32'(irq_out_ref(8'h00, 8'h02)));
        compare_value("irq_dsp_n", 32'(irq_dsp_n), 32'(irq_out_ref(8'h00, 8'h00)));
        finish_test("capture interrupts");

        apb_write(REG_IRQ, 32'h2000_2000); // Set line 5, DSP mask on line 5
        apb_read(REG_IRQ, rd);
        compare_value("irq_state[5]", 32'(rd[21]), 32'(1'b1));
        compare_value("irq_dsp_n", 32'(irq_dsp_n), 32'(irq_out_ref(8'h20, 8'h20)));
        compare_value("irq_smc_n", 32'(irq_smc_n), 32'(irq_out_ref(8'h20, 8'h00)));
        apb_write(REG_CAP_CNTRL, 32'h3);
        t_start = cycle_cnt;
        apb_read(REG_CAP_CNTRL, rd);
        compare_value("cap_busy", 32'(rd[2]), 32'(1'b1));
        apb_write(REG_CAP_CNTRL, 32'h3); // Ignored while busy
        wait_capture_idle();
        elapsed = int'(cycle_cnt - t_start);
        compare_value("capture length in range",
                      32'((elapsed >= BUF_DEPTH) && (elapsed <= BUF_DEPTH + 4)), 32'h1);
        apb_read(REG_CAP_ADDR, rd);
        compare_value("cap_wr_addr", 32'(rd[16 +: BUF_ADDR_W]), 32'h0);
        finish_test("software set and retrigger");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: verilog.f
logic/radio_pkg.sv
logic/radio_regs.sv
logic/led_pwm.sv
logic/irq_ctrl.sv
logic/adc_capture.sv
logic/radio_core.sv
verification/radio_core_sva.sv
verification/tb_radio_core.sv
